//--- filelist.f
+incdir+include
hdl/rv_pkg.sv
hdl/muldiv_pkg.sv
hdl/muldiv_multiplier.sv
hdl/muldiv_divider.sv
hdl/muldiv_unit.sv
testbench/muldiv_assertions.sv
testbench/muldiv_tb.sv

//--- testbench/muldiv_tb.sv
// Testbench for the M-extension unit.
// Runs a table of directed operations, a busy probe and LFSR operations, and
// compares every result and its latency with a 64-bit reference model.

`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_tb;
    import rv_pkg::*;
    import muldiv_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 8;
    localparam int MUL_LAT      = `MULDIV_MUL_STAGES + 1;
    localparam int DIV_LAT      = `MULDIV_DIV_ITERS + 2;
    localparam int N_TBL        = 34;
    localparam int N_RAND       = 200;
    localparam int DRAIN_CYCLES = 100;
    // Each test gets 40 cycles and the busy probe counts as one test.
    localparam int WATCHDOG_NS  = (N_TBL + N_RAND + 1) * 40 * CLK_NS
                                  + RESET_CYCLES * CLK_NS;

    typedef struct {
        muldiv_op_e op;
        word_t      a;
        word_t      b;
        bit         b2b;
    } stim_t;

    typedef struct {
        int         id;
        muldiv_op_e op;
        word_t      exp;
        int         cyc;
        int         lat;
    } pending_t;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    logic       i_valid;
    muldiv_op_e i_op;
    word_t      i_rs1;
    word_t      i_rs2;
    logic       o_ready;
    logic       o_valid;
    word_t      o_result;

    int          cyc        = 0;
    int          next_id    = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    logic [31:0] lfsr_state = 32'hcf9275d1;
    pending_t    pending [$];

    // Columns are op, rs1, rs2 and whether to issue on the very next cycle.
    stim_t stim_tbl [N_TBL] = '{
        // Multiply corner values.
        '{MUL,    32'h0000_0000, 32'h0000_0000, 1'b0},
        '{MUL,    32'h0000_0001, 32'hffff_ffff, 1'b0},
        '{MUL,    32'h7fff_ffff, 32'h7fff_ffff, 1'b0},
        '{MULH,   32'h8000_0000, 32'h8000_0000, 1'b0},
        '{MULH,   32'h8000_0000, 32'h7fff_ffff, 1'b0},
        '{MULH,   32'hffff_ffff, 32'hffff_ffff, 1'b0},
        '{MULHSU, 32'h8000_0000, 32'hffff_ffff, 1'b0},
        '{MULHSU, 32'hffff_ffff, 32'hffff_ffff, 1'b0},
        '{MULHSU, 32'h7fff_ffff, 32'h8000_0000, 1'b0},
        '{MULHU,  32'hffff_ffff, 32'hffff_ffff, 1'b0},
        '{MULHU,  32'h8000_0000, 32'h0000_0001, 1'b0},
        // A burst on consecutive cycles.
        '{MUL,    32'h1234_5678, 32'h9abc_def0, 1'b0},
        '{MULH,   32'h8000_0000, 32'h0000_0001, 1'b1},
        '{MULHSU, 32'hffff_ffff, 32'h0000_0002, 1'b1},
        '{MULHU,  32'hdead_beef, 32'hcafe_f00d, 1'b1},
        '{MUL,    32'hffff_ffff, 32'h8000_0000, 1'b1},
        '{MULH,   32'h7fff_ffff, 32'hffff_ffff, 1'b1},
        // Mixed-sign divides and remainders.
        '{DIV,    32'hffff_fff9, 32'h0000_0002, 1'b0},
        '{REM,    32'hffff_fff9, 32'h0000_0002, 1'b0},
        '{DIV,    32'h0000_0007, 32'hffff_fffe, 1'b0},
        '{REM,    32'h0000_0007, 32'hffff_fffe, 1'b0},
        '{DIV,    32'hffff_ff9c, 32'hffff_fff9, 1'b0},
        '{REM,    32'hffff_ff9c, 32'hffff_fff9, 1'b0},
        '{DIVU,   32'hffff_fff9, 32'h0000_0002, 1'b0},
        '{REMU,   32'hffff_fff9, 32'h0000_0002, 1'b0},
        // Division by zero and signed overflow.
        '{DIV,    32'h0000_1234, 32'h0000_0000, 1'b0},
        '{DIV,    32'hffff_fff0, 32'h0000_0000, 1'b0},
        '{DIVU,   32'h8000_0000, 32'h0000_0000, 1'b0},
        '{REM,    32'hffff_fff0, 32'h0000_0000, 1'b0},
        '{REMU,   32'h5555_aaaa, 32'h0000_0000, 1'b0},
        '{DIV,    32'h8000_0000, 32'hffff_ffff, 1'b0},
        '{REM,    32'h8000_0000, 32'hffff_ffff, 1'b0},
        // A multiply right before a divide must still come back first.
        '{MUL,    32'h0001_0001, 32'h0001_0001, 1'b0},
        '{DIV,    32'h0000_0064, 32'h0000_0007, 1'b1}
    };

    muldiv_unit u_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_rs1    (i_rs1),
        .i_rs2    (i_rs2),
        .o_ready  (o_ready),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    always #(CLK_NS / 2) i_clk = ~i_clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    // It steps once for each bit taken.
    function automatic word_t take_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // Reference results from plain 64-bit arithmetic.
    // Division truncates toward zero and a remainder takes the dividend's sign.
    function automatic word_t ref_model(input muldiv_op_e op, input word_t a, input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sprod;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        uprod;
        word_t              res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        res = '0;
        case (op)
            MUL: begin
                uprod = ua * ub;
                res   = uprod[31:0];
            end
            MULH: begin
                sprod = sa * sb;
                res   = sprod[63:32];
            end
            MULHSU: begin
                sprod = sa * $signed(ub);
                res   = sprod[63:32];
            end
            MULHU: begin
                uprod = ua * ub;
                res   = uprod[63:32];
            end
            DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (a == 32'h8000_0000 && b == '1) begin
                    res = 32'h8000_0000;
                end else begin
                    sprod = sa / sb;
                    res   = sprod[31:0];
                end
            end
            DIVU: begin
                uprod = (b == '0) ? 64'hffff_ffff : ua / ub;
                res   = uprod[31:0];
            end
            REM: begin
                if (b == '0) begin
                    res = a;
                end else if (a == 32'h8000_0000 && b == '1) begin
                    res = '0;
                end else begin
                    sprod = sa % sb;
                    res   = sprod[31:0];
                end
            end
            default: begin
                uprod = (b == '0) ? ua : ua % ub;
                res   = uprod[31:0];
            end
        endcase
        return res;
    endfunction

    task automatic check_result(input word_t got, input word_t exp, input string what,
                                output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error: %0t ns: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what,
                                 output bit ok);
        ok = (got == exp);
        if (!ok) begin
            $display("Error: %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what,
                               output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Error: %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Waits until every issued operation has returned or the drain bound runs out.
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (pending.size() != 0) begin
            $display("No result arrived for %0d operations, the first being test %0d",
                     pending.size(), pending[0].id);
            fail_count += pending.size();
            pending.delete();
        end
    endtask

    // Drives one operation and records what should come back.
    // The caller is always 1 ns past a rising edge here.
    task automatic issue_op(input muldiv_op_e op, input word_t a, input word_t b,
                            input bit b2b);
        pending_t ent;
        if (!b2b) begin
            wait_idle();
        end
        while (!o_ready) begin
            @(posedge i_clk);
            #1;
        end
        i_valid = 1'b1;
        i_op    = op;
        i_rs1   = a;
        i_rs2   = b;
        @(posedge i_clk);
        #1;
        i_valid = 1'b0;
        ent.id  = next_id;
        ent.op  = op;
        ent.exp = ref_model(op, a, b);
        ent.cyc = cyc;
        ent.lat = (op inside {DIV, DIVU, REM, REMU}) ? DIV_LAT : MUL_LAT;
        next_id++;
        pending.push_back(ent);
    endtask

    // Holds a multiply strobe while a divide runs.
    // The unit must drop it and return only the divide result.
    task automatic probe_busy_strobe();
        bit ok;
        bit all_ok;
        all_ok = 1'b1;
        issue_op(DIVU, 32'h1234_5678, 32'h0000_0123, 1'b0);
        i_valid = 1'b1;
        i_op    = MUL;
        i_rs1   = 32'h0000_0003;
        i_rs2   = 32'h0000_0005;
        repeat (10) begin
            check_level(o_ready, 1'b0, "o_ready during divide", ok);
            all_ok &= ok;
            @(posedge i_clk);
            #1;
        end
        i_valid = 1'b0;
        wait_idle();
        if (all_ok) begin
            pass_count++;
            $display("busy probe: ok");
        end else begin
            fail_count++;
            $display("busy probe: failed");
        end
    endtask

    // Pops the oldest outstanding operation on each result pulse.
    always @(posedge i_clk) begin
        pending_t cur;
        bit       ok_val;
        bit       ok_lat;
        string    tag;
        cyc = cyc + 1;
        if (i_rst_n === 1'b1 && o_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("Result %h at %0t ns came with no operation outstanding",
                         o_result, $time);
                fail_count++;
            end else begin
                cur = pending.pop_front();
                tag = $sformatf("test %0d %s", cur.id, cur.op.name());
                check_result(o_result, cur.exp, tag, ok_val);
                check_latency(cyc - cur.cyc, cur.lat, tag, ok_lat);
                if (ok_val && ok_lat) begin
                    pass_count++;
                    $display("%s: ok", tag);
                end else begin
                    fail_count++;
                    $display("%s: failed", tag);
                end
            end
        end
    end

    initial begin
        muldiv_op_e op;
        word_t      a;
        word_t      b;
        word_t      sh;
        bit         b2b;
        bit         ok_v;
        bit         ok_r;
        int         total_fail;
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_op    = MUL;
        i_rs1   = '0;
        i_rs2   = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_level(o_valid, 1'b0, "o_valid after reset", ok_v);
        check_level(o_ready, 1'b1, "o_ready after reset", ok_r);
        if (ok_v && ok_r) begin
            pass_count++;
            $display("reset state: ok");
        end else begin
            fail_count++;
            $display("reset state: failed");
        end
        for (int i = 0; i < N_TBL; i++) begin
            issue_op(stim_tbl[i].op, stim_tbl[i].a, stim_tbl[i].b, stim_tbl[i].b2b);
        end
        probe_busy_strobe();
        // Random divisors are shifted down so that divides give varied quotients.
        for (int i = 0; i < N_RAND; i++) begin
            op  = muldiv_op_e'(take_bits(3));
            a   = take_bits(32);
            b   = take_bits(32);
            sh  = take_bits(5);
            b2b = take_bits(1);
            b   = b >> sh;
            issue_op(op, a, b, b2b);
        end
        wait_idle();
        total_fail = fail_count + u_dut.u_assert.violations;
        $display("Summary: %0d tests passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, u_dut.u_assert.violations);
        if (total_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/muldiv_assertions.sv
// Concurrent checks on the M-extension unit, attached to muldiv_unit by bind.
// They cover the result merge, the fixed latencies and the busy level.

`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_assertions (
    input logic                   i_clk,
    input logic                   i_rst_n,
    input logic                   i_ready,
    input logic                   i_result_valid,
    input logic                   i_mul_valid,
    input logic                   i_mul_done,
    input logic                   i_div_start,
    input logic                   i_div_done,
    input muldiv_pkg::div_state_e i_div_state
);
    import muldiv_pkg::*;

    localparam int MUL_LAT = `MULDIV_MUL_STAGES + 1;
    localparam int DIV_LAT = `MULDIV_DIV_ITERS + 2;

    int violations = 0;

    // The two result sources share one output and must never pulse together.
    a_one_source: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_mul_done && i_div_done))
        else begin
            violations++;
            $error("multiplier and divider results pulsed in the same cycle");
        end

    // Every accepted multiply leaves the pipeline a fixed number of edges later.
    a_mul_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mul_valid |-> ##MUL_LAT i_mul_done)
        else begin
            violations++;
            $error("multiply result did not appear at the fixed latency");
        end

    // Load, the iterations and the fix-up edge give the divide latency.
    a_div_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_div_start |-> ##DIV_LAT i_result_valid)
        else begin
            violations++;
            $error("divide result did not appear at the fixed latency");
        end

    // The unit must refuse new work for the whole divide.
    a_busy_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_div_state != DIV_IDLE) |-> !i_ready)
        else begin
            violations++;
            $error("o_ready high while the divider was not idle");
        end

endmodule

bind muldiv_unit muldiv_assertions u_assert (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_ready        (o_ready),
    .i_result_valid (o_valid),
    .i_mul_valid    (mul_valid),
    .i_mul_done     (mul_valid_out),
    .i_div_start    (div_start),
    .i_div_done     (div_done),
    .i_div_state    (u_div.state)
);

//--- hdl/muldiv_unit.sv
// Top level of the M-extension execution unit.
// Accepts one operation per i_valid strobe while o_ready is high and routes
// it to the multiplier or the divider. Results from both return on one
// output as a single-cycle o_valid pulse.

`timescale 1ns/1ps

module muldiv_unit (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  muldiv_pkg::muldiv_op_e i_op,
    input  rv_pkg::word_t          i_rs1,
    input  rv_pkg::word_t          i_rs2,
    output logic                   o_ready,
    output logic                   o_valid,
    output rv_pkg::word_t          o_result
);
    import rv_pkg::*;
    import muldiv_pkg::*;

    // Issue side.
    logic accept;
    logic is_div;
    logic mul_valid;
    logic div_start;

    // Return side.
    logic  mul_valid_out;
    word_t mul_result;
    logic  div_busy;
    logic  div_done;
    word_t div_result;

    // A strobe counts only while the divider is idle.
    // The top bit of the opcode picks the destination.
    assign accept    = i_valid & o_ready;
    assign is_div    = op_is_div(i_op);
    assign mul_valid = accept & ~is_div;
    assign div_start = accept & is_div;

    muldiv_multiplier u_mul (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (mul_valid),
        .i_op           (i_op),
        .i_multiplicand (i_rs1),
        .i_multiplier   (i_rs2),
        .o_valid        (mul_valid_out),
        .o_result       (mul_result)
    );

    muldiv_divider u_div (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (div_start),
        .i_op       (i_op),
        .i_dividend (i_rs1),
        .i_divisor  (i_rs2),
        .o_busy     (div_busy),
        .o_done     (div_done),
        .o_result   (div_result)
    );

    // The unit is ready whenever the divider is not working.
    assign o_ready = ~div_busy;

    // Multiplies drain long before a divide that follows them can finish,
    // and none enter while the divider is busy.
    // At most one source pulses in any cycle, so a plain select is enough.
    assign o_valid  = mul_valid_out | div_done;
    assign o_result = div_done ? div_result : mul_result;

endmodule

//--- hdl/muldiv_divider.sv
// Iterative restoring divider for DIV, DIVU, REM and REMU.
// A start in DIV_IDLE loads the operand magnitudes, DIV_RUN takes one
// shift-subtract step per clock and DIV_FIX restores the signs and picks the
// quotient or remainder. The latency is the same for every operand value.

`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_divider (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  muldiv_pkg::muldiv_op_e i_op,
    input  rv_pkg::word_t          i_dividend,
    input  rv_pkg::word_t          i_divisor,
    output logic                   o_busy,
    output logic                   o_done,
    output rv_pkg::word_t          o_result
);
    import rv_pkg::*;
    import muldiv_pkg::*;

    localparam int XLEN  = `MULDIV_XLEN;
    localparam int CNT_W = $clog2(`MULDIV_DIV_ITERS);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(`MULDIV_DIV_ITERS - 1);

    // FSM and control flags.
    div_state_e       state;
    logic             busy;
    logic             done;
    logic [CNT_W-1:0] iter_cnt;

    // Decode of the incoming operation.
    logic  ld_signed;
    logic  ld_rem;
    logic  ld_a_neg;
    logic  ld_b_neg;
    word_t ld_a_mag;
    word_t ld_b_mag;

    // Working registers.
    // The upper word of acc is the partial remainder, the lower word collects
    // quotient bits while the dividend shifts out of it.
    dword_t acc;
    word_t  divisor_q;
    logic   q_neg;
    logic   r_neg;
    logic   div_zero;
    logic   want_rem;
    word_t  result_q;

    // One shift-subtract step.
    logic [XLEN:0] rem_shift;
    logic [XLEN:0] trial;
    word_t         rem_next;
    word_t         quo_next;

    // Sign-corrected results.
    word_t quo_fix;
    word_t rem_fix;

    // Signed operations divide magnitudes and fix the signs at the end.
    // The most negative value keeps its bit pattern when negated, which is
    // exactly its magnitude read as unsigned.
    always_comb begin
        ld_signed = (i_op == DIV) || (i_op == REM);
        ld_rem    = (i_op == REM) || (i_op == REMU);
        ld_a_neg  = ld_signed & i_dividend[XLEN-1];
        ld_b_neg  = ld_signed & i_divisor[XLEN-1];
        ld_a_mag  = ld_a_neg ? -i_dividend : i_dividend;
        ld_b_mag  = ld_b_neg ? -i_divisor : i_divisor;
    end

    // The partial remainder is shifted left with the next dividend bit.
    // It can reach one bit more than a word, so the trial subtraction is
    // one bit wider and its top bit tells whether the divisor fitted.
    always_comb begin
        rem_shift = acc[2*XLEN-1:XLEN-1];
        trial     = rem_shift - {1'b0, divisor_q};
        rem_next  = trial[XLEN] ? rem_shift[XLEN-1:0] : trial[XLEN-1:0];
        quo_next  = {acc[XLEN-2:0], ~trial[XLEN]};
    end

    // With a zero divisor every step succeeds.
    // The quotient comes out as all ones and the remainder as the dividend
    // magnitude, so only the quotient sign flip has to be held off.
    // The remainder always takes the sign of the dividend.
    always_comb begin
        if (div_zero) begin
            quo_fix = '1;
        end else if (q_neg) begin
            quo_fix = -acc[XLEN-1:0];
        end else begin
            quo_fix = acc[XLEN-1:0];
        end
        rem_fix = r_neg ? -acc[2*XLEN-1:XLEN] : acc[2*XLEN-1:XLEN];
    end

    // Control FSM.
    // The accepting edge is the load edge, then one edge per iteration and
    // one fix-up edge that raises o_done for a single cycle.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= DIV_IDLE;
            busy     <= 1'b0;
            done     <= 1'b0;
            iter_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (i_start) begin
                        state    <= DIV_RUN;
                        busy     <= 1'b1;
                        iter_cnt <= '0;
                    end
                end
                DIV_RUN: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == LAST_ITER) begin
                        state <= DIV_FIX;
                    end
                end
                DIV_FIX: begin
                    state <= DIV_IDLE;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                end
                default: begin
                    state <= DIV_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // Datapath registers follow the FSM state.
    always_ff @(posedge i_clk) begin
        case (state)
            DIV_IDLE: begin
                if (i_start) begin
                    acc       <= {{XLEN{1'b0}}, ld_a_mag};
                    divisor_q <= ld_b_mag;
                    q_neg     <= ld_a_neg ^ ld_b_neg;
                    r_neg     <= ld_a_neg;
                    div_zero  <= (i_divisor == '0);
                    want_rem  <= ld_rem;
                end
            end
            DIV_RUN: begin
                acc <= {rem_next, quo_next};
            end
            DIV_FIX: begin
                result_q <= want_rem ? rem_fix : quo_fix;
            end
            default: begin
            end
        endcase
    end

    assign o_busy   = busy;
    assign o_done   = done;
    assign o_result = result_q;

endmodule

//--- hdl/muldiv_multiplier.sv
// Pipelined 32 x 32 multiplier for the MUL, MULH, MULHSU and MULHU operations.
// One input flop stage is followed by the multiplier stages, so a result
// leaves a fixed number of cycles after it enters. A new operation may enter
// on every cycle and results leave in issue order.

`timescale 1ns/1ps
`include "muldiv_defs.svh"

module muldiv_multiplier (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_valid,
    input  muldiv_pkg::muldiv_op_e i_op,
    input  rv_pkg::word_t          i_multiplicand,
    input  rv_pkg::word_t          i_multiplier,
    output logic                   o_valid,
    output rv_pkg::word_t          o_result
);
    import rv_pkg::*;
    import muldiv_pkg::*;

    localparam int XLEN = `MULDIV_XLEN;
    localparam int LAST = `MULDIV_MUL_STAGES;

    // Bit 0 belongs to the input flop stage, bit LAST to the final stage.
    logic [LAST:0] stage_valid;

    // Input flop stage contents.
    muldiv_op_e stage0_op;
    word_t      stage0_a;
    word_t      stage0_b;

    // Operand extension and the product formed in stage one.
    logic                     a_signed;
    logic                     b_signed;
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] product;

    // Product and word select carried through the multiplier stages.
    dword_t [LAST:1] stage_prod;
    logic   [LAST:1] stage_upper;

    // The valid bits shift along with the data, one stage per clock.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[LAST-1:0], i_valid};
        end
    end

    // Input flop stage.
    always_ff @(posedge i_clk) begin
        stage0_op <= i_op;
        stage0_a  <= i_multiplicand;
        stage0_b  <= i_multiplier;
    end

    // Each operand gets one extra bit on top.
    // For a signed operand that bit copies the sign, otherwise it is zero.
    // Both extended operands are then signed, so a single signed multiply
    // gives the right product for every sign combination.
    always_comb begin
        a_signed = (stage0_op == MULH) || (stage0_op == MULHSU);
        b_signed = (stage0_op == MULH);
        a_ext    = signed'({a_signed & stage0_a[XLEN-1], stage0_a});
        b_ext    = signed'({b_signed & stage0_b[XLEN-1], stage0_b});
        product  = a_ext * b_ext;
    end

    // Stage one captures the low two words of the product.
    // The remaining stages only carry it forward.
    always_ff @(posedge i_clk) begin
        stage_prod[1]  <= product[2*XLEN-1:0];
        stage_upper[1] <= (stage0_op != MUL);
        for (int i = 2; i <= LAST; i++) begin
            stage_prod[i]  <= stage_prod[i-1];
            stage_upper[i] <= stage_upper[i-1];
        end
    end

    // MUL wants the low word, the three high variants want the upper word.
    assign o_valid  = stage_valid[LAST];
    assign o_result = stage_upper[LAST] ? stage_prod[LAST][2*XLEN-1:XLEN]
                                        : stage_prod[LAST][XLEN-1:0];

endmodule

//--- hdl/muldiv_pkg.sv
// Types of the M-extension execution unit.
// Holds the opcode encoding and the divider FSM states, plus a small helper
// that sorts opcodes into the multiply and divide groups.

package muldiv_pkg;

    // M-extension operations in RISC-V funct3 order.
    // The top bit is set for the four divide and remainder operations.
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } muldiv_op_e;

    // States of the iterative divider.
    // DIV_RUN lasts one cycle per iteration, DIV_FIX lasts a single cycle.
    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,
        DIV_RUN  = 2'b01,
        DIV_FIX  = 2'b10
    } div_state_e;

    // Returns one for operations that belong to the divider.
    function automatic logic op_is_div(input muldiv_op_e op);
        return op[2];
    endfunction

endpackage

//--- hdl/rv_pkg.sv
// Core-wide data types shared by every block of the core.
// Import it wherever a word or a double word crosses a port or is stored.

`include "muldiv_defs.svh"

package rv_pkg;

    // One architectural word.
    // Every operand and result port of the execution units uses this type.
    typedef logic [`MULDIV_XLEN-1:0] word_t;

    // Two words side by side.
    // The multiplier keeps its full product in this type.
    // The divider keeps its remainder in the upper word and its quotient in
    // the lower word.
    typedef logic [2*`MULDIV_XLEN-1:0] dword_t;

endpackage

//--- include/muldiv_defs.svh
// Sizing constants for the M-extension execution unit.
// Include this wherever the operand width, the multiplier depth or the
// divider iteration count is needed. The unit's fixed latencies follow from
// these values.

`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// Width of one operand or result word in bits.
`define MULDIV_XLEN 32

// Number of multiplier pipeline stages that follow the input flop stage.
// A multiply result therefore appears one stage later than this count
// after the operation is accepted.
`define MULDIV_MUL_STAGES 4

// Number of restoring shift-subtract steps the divider performs.
// One step is taken per clock, so this sets the length of the run phase.
`define MULDIV_DIV_ITERS 32

`endif
